// File: logic/game_pkg.sv
// game_pkg: shared piece, orientation and board coordinate types for the piece engine.
package game_pkg;

    localparam int num_tiles = 4; // every tetromino covers four cells.

    // row 0 is the top of the board. Subtraction wraps, so a row above the top reads as large.
    typedef logic [4:0] row_t;
    typedef logic [4:0] col_t;

    typedef enum logic [2:0] {
        i_piece = 3'd0,
        o_piece = 3'd1,
        t_piece = 3'd2,
        j_piece = 3'd3,
        l_piece = 3'd4,
        s_piece = 3'd5,
        z_piece = 3'd6
    } tile_type_t; // encoding 3'd7 is unused.

    typedef enum logic [1:0] {
        orientation_0 = 2'd0,
        orientation_r = 2'd1,
        orientation_2 = 2'd2,
        orientation_l = 2'd3
    } orientation_t;

endpackage

// File: logic/board_if.sv
// board_if: row lookup and lock write path between the move checker and the board store.
`timescale 1ns/10ps

interface board_if #(
    parameter int board_cols = 10
);
    import game_pkg::*;

    row_t                  lookup_row  [num_tiles]; // rows of the four candidate tiles.
    logic [board_cols-1:0] lookup_bits [num_tiles]; // occupancy of those rows, read back.
    logic                  lock_en;
    row_t                  lock_row    [num_tiles];
    col_t                  lock_col    [num_tiles];

    modport checker_mp (
        output lookup_row,
        input  lookup_bits,
        output lock_en,
        output lock_row,
        output lock_col
    );

    modport store_mp (
        input  lookup_row,
        output lookup_bits,
        input  lock_en,
        input  lock_row,
        input  lock_col
    );

endinterface

// File: logic/piece_tiles.sv
// piece_tiles: maps a tetromino type, orientation and origin to its four board tiles.
`timescale 1ns/10ps

module piece_tiles (
    input  game_pkg::tile_type_t   piece_type,
    input  game_pkg::orientation_t orientation,
    input  game_pkg::row_t         origin_row,
    input  game_pkg::col_t         origin_col,
    output game_pkg::row_t         tile_row [game_pkg::num_tiles],
    output game_pkg::col_t         tile_col [game_pkg::num_tiles]
);
    import game_pkg::*;

    // offsets of the pieces that turn about their centre tile, in orientation 0.
    logic signed [1:0] base_dr [num_tiles];
    logic signed [1:0] base_dc [num_tiles];
    logic signed [1:0] rot_dr  [num_tiles];
    logic signed [1:0] rot_dc  [num_tiles];

    function automatic logic [4:0] sext(input logic signed [1:0] d);
        return {{3{d[1]}}, d};
    endfunction

    always_comb begin
        case (piece_type)
            j_piece: begin
                base_dr = '{2'sd0, 2'sd0, -2'sd1, 2'sd0};
                base_dc = '{2'sd0, -2'sd1, -2'sd1, 2'sd1};
            end
            l_piece: begin
                base_dr = '{2'sd0, 2'sd0, -2'sd1, 2'sd0};
                base_dc = '{2'sd0, -2'sd1, 2'sd1, 2'sd1};
            end
            s_piece: begin
                base_dr = '{2'sd0, -2'sd1, -2'sd1, 2'sd0};
                base_dc = '{2'sd0, 2'sd0, 2'sd1, -2'sd1};
            end
            z_piece: begin
                base_dr = '{2'sd0, 2'sd0, -2'sd1, -2'sd1};
                base_dc = '{2'sd0, 2'sd1, -2'sd1, 2'sd0};
            end
            default: begin // T shape, also a harmless filler for I and O.
                base_dr = '{2'sd0, 2'sd0, -2'sd1, 2'sd0};
                base_dc = '{2'sd0, -2'sd1, 2'sd0, 2'sd1};
            end
        endcase
    end

    // a clockwise quarter turn takes (dr, dc) to (dc, -dr) with rows counting downward.
    always_comb begin
        for (int k = 0; k < num_tiles; k++) begin
            case (orientation)
                orientation_0: begin
                    rot_dr[k] = base_dr[k];
                    rot_dc[k] = base_dc[k];
                end
                orientation_r: begin
                    rot_dr[k] = base_dc[k];
                    rot_dc[k] = -base_dr[k];
                end
                orientation_2: begin
                    rot_dr[k] = -base_dr[k];
                    rot_dc[k] = -base_dc[k];
                end
                default: begin
                    rot_dr[k] = -base_dc[k];
                    rot_dc[k] = base_dr[k];
                end
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k < num_tiles; k++) begin
            case (piece_type)
                i_piece: begin
                    case (orientation)
                        orientation_0: begin
                            tile_row[k] = origin_row - 5'd1;
                            tile_col[k] = origin_col + col_t'(2 - k);
                        end
                        orientation_r: begin
                            tile_row[k] = origin_row + row_t'(1 - k);
                            tile_col[k] = origin_col + 5'd1;
                        end
                        orientation_2: begin
                            tile_row[k] = origin_row;
                            tile_col[k] = origin_col + col_t'(2 - k);
                        end
                        default: begin
                            tile_row[k] = origin_row + row_t'(1 - k);
                            tile_col[k] = origin_col;
                        end
                    endcase
                end
                o_piece: begin
                    tile_row[k] = origin_row - row_t'(k % 2); // origin is the bottom-left cell.
                    tile_col[k] = origin_col + col_t'(k / 2);
                end
                t_piece, j_piece, l_piece, s_piece, z_piece: begin
                    tile_row[k] = origin_row + sext(rot_dr[k]);
                    tile_col[k] = origin_col + sext(rot_dc[k]);
                end
                default: begin
                    tile_row[k] = '0;
                    tile_col[k] = '0;
                end
            endcase
        end
    end

endmodule

// File: logic/board_store.sv
// board_store: playfield occupancy rows with four combinational lookups, a lock write and a clear.
`timescale 1ns/10ps

module board_store #(
    parameter int board_rows = 20,
    parameter int board_cols = 10
) (
    input logic       clk,
    input logic       reset,
    input logic       clear,
    board_if.store_mp bus
);
    import game_pkg::*;

    localparam logic [board_cols-1:0] cell_one = 1;

    logic [board_cols-1:0] occupancy [board_rows];
    logic [board_cols-1:0] lock_mask [board_rows];

    always_comb begin
        for (int k = 0; k < num_tiles; k++) begin
            if (int'(bus.lookup_row[k]) < board_rows) begin
                bus.lookup_bits[k] = occupancy[bus.lookup_row[k]];
            end else begin
                bus.lookup_bits[k] = '0; // off the board reads as empty.
            end
        end
    end

    // gather all four tiles per row first, since two tiles may share a row.
    always_comb begin
        for (int r = 0; r < board_rows; r++) begin
            lock_mask[r] = '0;
            for (int k = 0; k < num_tiles; k++) begin
                if (bus.lock_row[k] == row_t'(r)) begin
                    lock_mask[r] = lock_mask[r] | (cell_one << bus.lock_col[k]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int r = 0; r < board_rows; r++) begin
                occupancy[r] <= '0;
            end
        end else if (bus.lock_en) begin
            for (int r = 0; r < board_rows; r++) begin
                occupancy[r] <= occupancy[r] | lock_mask[r];
            end
        end
    end

endmodule

// File: logic/move_checker.sv
// move_checker: judges bounds and overlap of a placement, locks legal pieces and holds the response.
`timescale 1ns/10ps

module move_checker #(
    parameter int board_rows = 20,
    parameter int board_cols = 10
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic                   req_lock,
    input  game_pkg::row_t         tile_row     [game_pkg::num_tiles],
    input  game_pkg::col_t         tile_col     [game_pkg::num_tiles],
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic                   rsp_legal,
    output game_pkg::row_t         rsp_tile_row [game_pkg::num_tiles],
    output game_pkg::col_t         rsp_tile_col [game_pkg::num_tiles],
    board_if.checker_mp            bus
);
    import game_pkg::*;

    localparam logic [board_cols-1:0] cell_one = 1;

    logic accept;
    logic in_bounds;
    logic overlap;
    logic legal;

    // a held response that leaves this cycle frees the slot for the next request.
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    always_comb begin
        in_bounds = 1'b1;
        overlap   = 1'b0;
        for (int k = 0; k < num_tiles; k++) begin
            bus.lookup_row[k] = tile_row[k];
            bus.lock_row[k]   = tile_row[k];
            bus.lock_col[k]   = tile_col[k];
            if (int'(tile_row[k]) >= board_rows || int'(tile_col[k]) >= board_cols) begin
                in_bounds = 1'b0; // wrapped rows and columns land here too.
            end
            if ((bus.lookup_bits[k] & (cell_one << tile_col[k])) != '0) begin
                overlap = 1'b1;
            end
        end
    end

    assign legal       = in_bounds && !overlap;
    assign bus.lock_en = accept && req_lock && legal; // written at the same edge as the accept.

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_legal    <= legal;
            rsp_tile_row <= tile_row;
            rsp_tile_col <= tile_col;
        end
    end

endmodule

// File: logic/piece_engine_top.sv
// piece_engine_top: tetromino placement engine joining the tile map, move checker and board store.
`timescale 1ns/10ps

module piece_engine_top #(
    parameter int board_rows = 20,
    parameter int board_cols = 10
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   board_clear,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  game_pkg::tile_type_t   req_type,
    input  game_pkg::orientation_t req_orientation,
    input  game_pkg::row_t         req_row,
    input  game_pkg::col_t         req_col,
    input  logic                   req_lock,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic                   rsp_legal,
    output game_pkg::row_t         rsp_tile_row [game_pkg::num_tiles],
    output game_pkg::col_t         rsp_tile_col [game_pkg::num_tiles]
);
    import game_pkg::*;

    row_t tile_row [num_tiles];
    col_t tile_col [num_tiles];

    board_if #(.board_cols(board_cols)) board_bus ();

    piece_tiles piece_tiles_i (
        .piece_type  (req_type),
        .orientation (req_orientation),
        .origin_row  (req_row),
        .origin_col  (req_col),
        .tile_row    (tile_row),
        .tile_col    (tile_col)
    );

    move_checker #(
        .board_rows (board_rows),
        .board_cols (board_cols)
    ) move_checker_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_lock     (req_lock),
        .tile_row     (tile_row),
        .tile_col     (tile_col),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_legal    (rsp_legal),
        .rsp_tile_row (rsp_tile_row),
        .rsp_tile_col (rsp_tile_col),
        .bus          (board_bus.checker_mp)
    );

    board_store #(
        .board_rows (board_rows),
        .board_cols (board_cols)
    ) board_store_i (
        .clk   (clk),
        .reset (reset),
        .clear (board_clear),
        .bus   (board_bus.store_mp)
    );

endmodule

// File: dv/tb_clock.sv
// tb_clock: free-running testbench clock.
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

// File: dv/piece_engine_properties.sv
// piece_engine_properties: reset and valid/ready checks bound into the piece engine top level.
`timescale 1ns/10ps

module piece_engine_properties (
    input logic           clk,
    input logic           reset,
    input logic           req_ready,
    input logic           rsp_valid,
    input logic           rsp_ready,
    input logic           rsp_legal,
    input game_pkg::row_t rsp_tile_row [game_pkg::num_tiles],
    input game_pkg::col_t rsp_tile_col [game_pkg::num_tiles]
);
    import game_pkg::*;

    logic [40:0] held; // verdict and all eight coordinates of the held response.

    assign held = {rsp_legal, rsp_tile_row[0], rsp_tile_row[1], rsp_tile_row[2], rsp_tile_row[3],
                   rsp_tile_col[0], rsp_tile_col[1], rsp_tile_col[2], rsp_tile_col[3]};

    rsp_idle_in_reset: assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("rsp_valid is high after a reset cycle");

    rsp_held_stable: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(held))
        else $error("held response changed while rsp_ready was low");

    // one item in flight, so a stalled response blocks the request side.
    no_accept_while_held: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |-> !req_ready)
        else $error("req_ready is high while a response is held");

endmodule

bind piece_engine_top piece_engine_properties piece_engine_properties_i (.*);

// File: dv/piece_engine_tb.sv
// piece_engine_tb: directed and random tests of tile mapping, bounds, locking and handshakes.
`timescale 1ns/10ps

module piece_engine_tb;
    import game_pkg::*;

    localparam int board_rows = 20;
    localparam int board_cols = 10;
    localparam int timeout_cycles = 50;

    // orientation 0 (row, col) pairs of tiles 0..3 for T, J, L, S and Z; tile 0 is the centre.
    localparam int shape_offsets [5][8] = '{
        '{0, 0, 0, -1, -1, 0, 0, 1},
        '{0, 0, 0, -1, -1, -1, 0, 1},
        '{0, 0, 0, -1, -1, 1, 0, 1},
        '{0, 0, -1, 0, -1, 1, 0, -1},
        '{0, 0, 0, 1, -1, -1, -1, 0}
    };

    logic clk, reset, board_clear, req_valid, req_ready, req_lock;
    logic rsp_valid, rsp_ready, rsp_legal;
    tile_type_t req_type;
    orientation_t req_orientation;
    row_t req_row;
    col_t req_col;
    row_t rsp_tile_row [num_tiles];
    col_t rsp_tile_col [num_tiles];

    logic [board_cols-1:0] board_model [board_rows];
    row_t m_row [num_tiles];
    col_t m_col [num_tiles];
    logic m_legal;
    logic m_lock;
    logic [40:0] exp_q [$];
    int want_q [$];

    tb_clock #(.period_ns(20)) tb_clock_i (.clk(clk));

    piece_engine_top #(
        .board_rows (board_rows),
        .board_cols (board_cols)
    ) piece_engine_top_i (.*);

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [40:0] pack_rsp(input logic legal, input row_t rows [num_tiles],
                                             input col_t cols [num_tiles]);
        return {legal, rows[0], rows[1], rows[2], rows[3], cols[0], cols[1], cols[2], cols[3]};
    endfunction

    // reference tiles and verdict, judged against the board model.
    task automatic model_request(input int t, input int o, input int r, input int c);
        int br;
        int bc;
        int dr;
        int dc;
        m_legal = 1'b1;
        for (int k = 0; k < num_tiles; k++) begin
            br = (t >= 2) ? shape_offsets[t-2][2*k] : 0;
            bc = (t >= 2) ? shape_offsets[t-2][2*k+1] : 0;
            case (o)
                1: begin
                    dr = bc;
                    dc = -br;
                end
                2: begin
                    dr = -br;
                    dc = -bc;
                end
                3: begin
                    dr = -bc;
                    dc = br;
                end
                default: begin
                    dr = br;
                    dc = bc;
                end
            endcase
            if (t == 0) begin // I lies on row origin-1 or the origin row, or stands upright.
                dr = (o == 0) ? -1 : (o == 2) ? 0 : 1 - k;
                dc = (o == 1) ? 1 : (o == 3) ? 0 : 2 - k;
            end else if (t == 1) begin // O grows up and right from its bottom-left tile.
                dr = -(k % 2);
                dc = k / 2;
            end
            m_row[k] = row_t'(r + dr);
            m_col[k] = col_t'(c + dc);
            if (int'(m_row[k]) >= board_rows || int'(m_col[k]) >= board_cols) begin
                m_legal = 1'b0;
            end else if (board_model[m_row[k]][m_col[k]]) begin
                m_legal = 1'b0;
            end
        end
    endtask

    task automatic drive_req(input tile_type_t t, input orientation_t o, input int r, input int c,
                             input logic lock, input int want);
        model_request(int'(t), int'(o), r, c);
        m_lock = lock;
        exp_q.push_back(pack_rsp(m_legal, m_row, m_col));
        want_q.push_back(want); // negative means the verdict is left to the model.
        @(posedge clk);
        req_valid <= 1'b1;
        req_type <= t;
        req_orientation <= o;
        req_row <= row_t'(r);
        req_col <= col_t'(c);
        req_lock <= lock;
    endtask

    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > timeout_cycles) abort_run("timeout: the request was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        if (m_lock && m_legal) begin
            for (int k = 0; k < num_tiles; k++) board_model[m_row[k]][m_col[k]] = 1'b1;
        end
    endtask

    task automatic check_held(input logic [40:0] want_rsp);
        @(negedge clk);
        assert (rsp_valid && !req_ready &&
                pack_rsp(rsp_legal, rsp_tile_row, rsp_tile_col) == want_rsp)
            else abort_run($sformatf("** Error at %0t: held response moved or request accepted",
                                     $time));
    endtask

    task automatic take_rsp(input int stall);
        logic [40:0] want_rsp;
        logic [40:0] got;
        int want;
        int waited;
        want_rsp = exp_q.pop_front();
        want = want_q.pop_front();
        waited = 0;
        repeat (stall) check_held(want_rsp);
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(negedge clk);
        while (!rsp_valid) begin
            waited++;
            if (waited > timeout_cycles) abort_run("timeout: no response arrived");
            @(negedge clk);
        end
        got = pack_rsp(rsp_legal, rsp_tile_row, rsp_tile_col);
        assert (got == want_rsp)
            else abort_run($sformatf("** Error at %0t: response %h, expected %h", $time, got,
                                     want_rsp));
        assert (want < 0 || rsp_legal == want[0])
            else abort_run($sformatf("** Error at %0t: rsp_legal is %b, expected %0d", $time,
                                     rsp_legal, want));
        @(posedge clk);
        rsp_ready <= 1'b0;
    endtask

    task automatic place(input tile_type_t t, input orientation_t o, input int r, input int c,
                         input logic lock, input int want);
        drive_req(t, o, r, c, lock, want);
        wait_accept();
        take_rsp(0);
    endtask

    task automatic tile_map_sweep();
        for (int t = 0; t < 7; t++) begin
            for (int o = 0; o < 4; o++) place(tile_type_t'(t), orientation_t'(o), 10, 5, 1'b0, 1);
        end
    endtask

    task automatic bounds_edges();
        place(t_piece, orientation_0, 0, 5, 1'b0, 0); // row -1 wraps to 31.
        place(t_piece, orientation_0, 1, 5, 1'b0, 1);
        place(t_piece, orientation_0, 10, 0, 1'b0, 0);
        place(t_piece, orientation_0, 10, 1, 1'b0, 1);
        place(t_piece, orientation_0, 10, 9, 1'b0, 0);
        place(t_piece, orientation_0, 10, 8, 1'b0, 1);
        place(t_piece, orientation_2, 19, 5, 1'b0, 0);
        place(t_piece, orientation_2, 18, 5, 1'b0, 1);
        place(i_piece, orientation_0, 0, 4, 1'b0, 0);
        place(i_piece, orientation_0, 1, 4, 1'b0, 1);
        place(i_piece, orientation_0, 10, 0, 1'b0, 0);
        place(i_piece, orientation_0, 10, 1, 1'b0, 1);
        place(i_piece, orientation_l, 19, 5, 1'b0, 0);
        place(i_piece, orientation_l, 18, 5, 1'b0, 1);
    endtask

    task automatic lock_and_overlap();
        place(o_piece, orientation_0, 19, 0, 1'b1, 1);
        place(t_piece, orientation_0, 18, 1, 1'b0, 0);
        place(t_piece, orientation_0, 19, 3, 1'b0, 1);
        place(t_piece, orientation_0, 18, 1, 1'b1, 0);
        place(t_piece, orientation_2, 17, 2, 1'b0, 1); // cells the refused lock would have set.
    endtask

    task automatic hold_under_backpressure();
        int stall;
        stall = $urandom_range(5, 1);
        drive_req(t_piece, orientation_0, 10, 5, 1'b0, 1);
        wait_accept();
        drive_req(j_piece, orientation_r, 5, 5, 1'b0, 1);
        repeat (stall) check_held(exp_q[0]);
        @(posedge clk);
        rsp_ready <= 1'b1;
        wait_accept(); // the held response leaves at the edge that takes the next request.
        rsp_ready <= 1'b0;
        void'(exp_q.pop_front());
        void'(want_q.pop_front());
        take_rsp(0);
    endtask

    task automatic clear_board();
        place(i_piece, orientation_0, 11, 3, 1'b1, 1);
        place(t_piece, orientation_0, 5, 5, 1'b1, 1);
        place(t_piece, orientation_0, 10, 5, 1'b0, 0);
        place(o_piece, orientation_0, 19, 0, 1'b0, 0);
        @(posedge clk);
        board_clear <= 1'b1;
        @(posedge clk);
        board_clear <= 1'b0;
        for (int r = 0; r < board_rows; r++) board_model[r] = '0;
        place(t_piece, orientation_0, 10, 5, 1'b0, 1);
        place(o_piece, orientation_0, 19, 0, 1'b0, 1);
        place(t_piece, orientation_0, 5, 5, 1'b0, 1);
    endtask

    task automatic random_sweep();
        for (int n = 0; n < 200; n++) begin
            drive_req(tile_type_t'($urandom_range(6, 0)), orientation_t'($urandom_range(3, 0)),
                      int'($urandom_range(31, 0)), int'($urandom_range(31, 0)),
                      $urandom_range(3, 0) == 0, -1);
            wait_accept();
            take_rsp(int'($urandom_range(3, 0)));
        end
    endtask

    initial begin
        reset = 1'b1;
        board_clear = 1'b0;
        req_valid = 1'b0;
        req_type = i_piece;
        req_orientation = orientation_0;
        req_row = '0;
        req_col = '0;
        req_lock = 1'b0;
        rsp_ready = 1'b0;
        for (int r = 0; r < board_rows; r++) board_model[r] = '0;
        void'($urandom(32'h4d00_22cb));
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        tile_map_sweep();
        bounds_edges();
        lock_and_overlap();
        hold_under_backpressure();
        clear_board();
        random_sweep();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: all.f
logic/game_pkg.sv
logic/board_if.sv
logic/piece_tiles.sv
logic/board_store.sv
logic/move_checker.sv
logic/piece_engine_top.sv
dv/tb_clock.sv
dv/piece_engine_properties.sv
dv/piece_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := piece_engine_tb
FILELIST  := all.f
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
